//--- common/mips_pkg.sv
package mips_pkg;

    // ========================================================================
    // widths and basic types
    // ========================================================================

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ========================================================================
    // primary opcodes, inst[31:26]
    // ========================================================================

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_PREF    = 6'b110011;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;

    // special function field, inst[5:0].
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_SYNC = 6'b001111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;

    // ========================================================================
    // alu encodings and pipeline records
    // ========================================================================

    // immediate and variable forms share one value.
    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NOP,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH
    } alu_sel_e;

    typedef struct packed {
        alu_op_e   op;
        alu_sel_e  sel;
        logic      rd1_en;
        logic      rd2_en;
        reg_addr_t rd1_addr;
        reg_addr_t rd2_addr;
        reg_addr_t waddr;
        logic      wen;
        word_t     imm;
    } decode_t;

    typedef struct packed {
        alu_op_e   op;
        alu_sel_e  sel;
        word_t     opnd1;
        word_t     opnd2;
        reg_addr_t waddr;
        logic      wen;
    } id_ex_t;

    typedef struct packed {
        logic      wen;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_t;

endpackage

//--- id/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  mips_pkg::word_t   inst_i,
    output mips_pkg::decode_t dec_o
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  sa;
    logic [15:0] imm16;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    alu_sel_e    r_sel;
    logic        fixed_shift;
    logic        writes;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign sa     = inst_i[10:6];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    function automatic alu_op_e funct_op(input logic [5:0] fn);
        case (fn)
            FN_OR:                    return ALU_OR;
            FN_AND:                   return ALU_AND;
            FN_XOR:                   return ALU_XOR;
            FN_NOR:                   return ALU_NOR;
            FN_SLL, FN_SLLV:          return ALU_SLL;
            FN_SRL, FN_SRLV:          return ALU_SRL;
            FN_SRA, FN_SRAV:          return ALU_SRA;
            FN_ADD, FN_ADDU:          return ALU_ADD;
            FN_SUB, FN_SUBU:          return ALU_SUB;
            FN_SLT:                   return ALU_SLT;
            FN_SLTU:                  return ALU_SLTU;
            default:                  return ALU_NOP;
        endcase
    endfunction

    // lui is an or with zero.
    function automatic alu_op_e imm_op(input logic [5:0] opc);
        case (opc)
            OP_ORI, OP_LUI:           return ALU_OR;
            OP_ANDI:                  return ALU_AND;
            OP_XORI:                  return ALU_XOR;
            OP_ADDI, OP_ADDIU:        return ALU_ADD;
            OP_SLTI:                  return ALU_SLT;
            OP_SLTIU:                 return ALU_SLTU;
            default:                  return ALU_NOP;
        endcase
    endfunction

    always_comb begin
        dec_o.op       = ALU_NOP;
        dec_o.sel      = SEL_NOP;
        dec_o.rd1_en   = 1'b0;
        dec_o.rd2_en   = 1'b0;
        dec_o.rd1_addr = rs;
        dec_o.rd2_addr = rt;
        dec_o.waddr    = rd;
        dec_o.imm      = '0;
        r_sel          = SEL_NOP;
        fixed_shift    = 1'b0;
        writes         = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_OR, FN_AND, FN_XOR, FN_NOR: r_sel = SEL_LOGIC;
                    FN_SLLV, FN_SRLV, FN_SRAV,
                    FN_SLL, FN_SRL, FN_SRA:       r_sel = SEL_SHIFT;
                    FN_SLT, FN_SLTU, FN_ADD,
                    FN_ADDU, FN_SUB, FN_SUBU:     r_sel = SEL_ARITH;
                    // barrier only.
                    FN_SYNC:                      r_sel = SEL_NOP;
                    default:                      r_sel = SEL_NOP;
                endcase
                fixed_shift = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);
                // fixed shifts need rs zero, the rest need sa zero.
                if (r_sel != SEL_NOP && (fixed_shift ? (rs == '0) : (sa == '0))) begin
                    dec_o.op     = funct_op(funct);
                    dec_o.sel    = r_sel;
                    dec_o.rd1_en = !fixed_shift;
                    dec_o.rd2_en = 1'b1;
                    dec_o.imm    = {{(DATA_W-5){1'b0}}, sa};
                    writes       = 1'b1;
                end
            end

            OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: begin
                dec_o.op     = imm_op(opcode);
                dec_o.sel    = (opcode inside {OP_ORI, OP_ANDI, OP_XORI, OP_LUI}) ?
                               SEL_LOGIC : SEL_ARITH;
                dec_o.rd1_en = 1'b1;
                dec_o.waddr  = rt;
                writes       = 1'b1;
                case (opcode)
                    OP_LUI: begin
                        dec_o.rd1_addr = '0;
                        dec_o.imm      = {imm16, 16'h0000};
                    end
                    OP_ORI, OP_ANDI, OP_XORI: begin
                        dec_o.imm = {16'h0000, imm16};
                    end
                    // sltiu also sign-extends.
                    default: begin
                        dec_o.imm = {{16{imm16[15]}}, imm16};
                    end
                endcase
            end

            // prefetch is a hint with no effect here.
            OP_PREF: begin
                writes = 1'b0;
            end

            default: begin
                writes = 1'b0;
            end
        endcase

        // r0 never written, so it is never forwarded either.
        dec_o.wen = writes && (dec_o.waddr != '0);
    end

endmodule

//--- id/operand_fwd.sv
`timescale 1ns/100ps

module operand_fwd (
    input  mips_pkg::decode_t dec_i,
    input  mips_pkg::word_t   rd1_data_i,
    input  mips_pkg::word_t   rd2_data_i,
    input  mips_pkg::wb_t     ex_fwd_i,
    input  mips_pkg::wb_t     mem_fwd_i,
    output mips_pkg::word_t   opnd1_o,
    output mips_pkg::word_t   opnd2_o
);
    import mips_pkg::*;

    // execute beats memory beats the register file.
    function automatic word_t pick(
        input logic      en,
        input reg_addr_t addr,
        input word_t     rf_data,
        input word_t     imm,
        input wb_t       ex,
        input wb_t       mem
    );
        if (!en) begin
            return imm;
        end
        if (ex.wen && ex.waddr == addr) begin
            return ex.wdata;
        end
        if (mem.wen && mem.waddr == addr) begin
            return mem.wdata;
        end
        return rf_data;
    endfunction

    assign opnd1_o = pick(dec_i.rd1_en, dec_i.rd1_addr, rd1_data_i, dec_i.imm,
                          ex_fwd_i, mem_fwd_i);
    assign opnd2_o = pick(dec_i.rd2_en, dec_i.rd2_addr, rd2_data_i, dec_i.imm,
                          ex_fwd_i, mem_fwd_i);

endmodule

//--- id/id_stage.sv
`timescale 1ns/100ps

module id_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                inst_valid_i,
    input  mips_pkg::word_t     inst_i,
    input  mips_pkg::word_t     rd1_data_i,
    input  mips_pkg::word_t     rd2_data_i,
    input  mips_pkg::wb_t       ex_fwd_i,
    input  mips_pkg::wb_t       mem_fwd_i,
    output mips_pkg::reg_addr_t rd1_addr_o,
    output mips_pkg::reg_addr_t rd2_addr_o,
    output mips_pkg::id_ex_t    id_ex_o
);
    import mips_pkg::*;

    decode_t dec;
    word_t   opnd1;
    word_t   opnd2;
    id_ex_t  id_ex_q;

    inst_decoder u_dec (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    operand_fwd u_fwd (
        .dec_i      (dec),
        .rd1_data_i (rd1_data_i),
        .rd2_data_i (rd2_data_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .opnd1_o    (opnd1),
        .opnd2_o    (opnd2)
    );

    assign rd1_addr_o = dec.rd1_addr;
    assign rd2_addr_o = dec.rd2_addr;

    // ========================================================================
    // decode/execute register
    // ========================================================================

    always_ff @(posedge clk_i) begin
        id_ex_q.opnd1 <= opnd1;
        id_ex_q.opnd2 <= opnd2;
        id_ex_q.waddr <= dec.waddr;
        // idle cycles become bubbles.
        if (rst_i || !inst_valid_i) begin
            id_ex_q.op  <= ALU_NOP;
            id_ex_q.sel <= SEL_NOP;
            id_ex_q.wen <= 1'b0;
        end else begin
            id_ex_q.op  <= dec.op;
            id_ex_q.sel <= dec.sel;
            id_ex_q.wen <= dec.wen;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

//--- ex/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic             clk_i,
    input  logic             rst_i,
    input  mips_pkg::id_ex_t id_ex_i,
    output mips_pkg::wb_t    ex_fwd_o,
    output mips_pkg::wb_t    mem_fwd_o
);
    import mips_pkg::*;

    word_t      a;
    word_t      b;
    logic [4:0] shamt;
    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;
    word_t      result;
    wb_t        mem_q;

    assign a     = id_ex_i.opnd1;
    assign b     = id_ex_i.opnd2;
    assign shamt = a[4:0];

    always_comb begin
        case (id_ex_i.op)
            ALU_OR:  logic_res = a | b;
            ALU_AND: logic_res = a & b;
            ALU_XOR: logic_res = a ^ b;
            ALU_NOR: logic_res = ~(a | b);
            default: logic_res = '0;
        endcase
    end

    // operand 2 is shifted by operand 1.
    always_comb begin
        case (id_ex_i.op)
            ALU_SLL: shift_res = b << shamt;
            ALU_SRL: shift_res = b >> shamt;
            ALU_SRA: shift_res = word_t'($signed(b) >>> shamt);
            default: shift_res = '0;
        endcase
    end

    // add and sub wrap, no overflow trap.
    always_comb begin
        case (id_ex_i.op)
            ALU_ADD:  arith_res = a + b;
            ALU_SUB:  arith_res = a - b;
            ALU_SLT:  arith_res = word_t'($signed(a) < $signed(b));
            ALU_SLTU: arith_res = word_t'(a < b);
            default:  arith_res = '0;
        endcase
    end

    always_comb begin
        case (id_ex_i.sel)
            SEL_LOGIC: result = logic_res;
            SEL_SHIFT: result = shift_res;
            SEL_ARITH: result = arith_res;
            default:   result = '0;
        endcase
    end

    assign ex_fwd_o = '{wen: id_ex_i.wen, waddr: id_ex_i.waddr, wdata: result};

    // ========================================================================
    // execute/memory register
    // ========================================================================

    always_ff @(posedge clk_i) begin
        mem_q.waddr <= id_ex_i.waddr;
        mem_q.wdata <= result;
        if (rst_i) begin
            mem_q.wen <= 1'b0;
        end else begin
            mem_q.wen <= id_ex_i.wen;
        end
    end

    assign mem_fwd_o = mem_q;

endmodule

//--- hdl/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                clk_i,
    input  logic                rst_i,
    input  mips_pkg::reg_addr_t rd1_addr_i,
    input  mips_pkg::reg_addr_t rd2_addr_i,
    output mips_pkg::word_t     rd1_data_o,
    output mips_pkg::word_t     rd2_data_o,
    input  mips_pkg::wb_t       wr_i
);
    import mips_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.wen && wr_i.waddr != '0) begin
            regs[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // r0 reads as zero.
    assign rd1_data_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];

endmodule

//--- hdl/mips_core.sv
`timescale 1ns/100ps

module mips_core (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                inst_valid_i,
    input  mips_pkg::word_t     inst_i,
    output logic                wb_valid_o,
    output mips_pkg::reg_addr_t wb_addr_o,
    output mips_pkg::word_t     wb_data_o
);
    import mips_pkg::*;

    id_ex_t    id_ex;
    wb_t       ex_fwd;
    wb_t       mem_fwd;
    reg_addr_t rd1_addr;
    reg_addr_t rd2_addr;
    word_t     rd1_data;
    word_t     rd2_data;

    id_stage u_id (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rd1_data_i   (rd1_data),
        .rd2_data_i   (rd2_data),
        .ex_fwd_i     (ex_fwd),
        .mem_fwd_i    (mem_fwd),
        .rd1_addr_o   (rd1_addr),
        .rd2_addr_o   (rd2_addr),
        .id_ex_o      (id_ex)
    );

    ex_stage u_ex (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .id_ex_i   (id_ex),
        .ex_fwd_o  (ex_fwd),
        .mem_fwd_o (mem_fwd)
    );

    // mem_fwd is also the write port.
    regfile u_rf (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd1_addr_i (rd1_addr),
        .rd2_addr_i (rd2_addr),
        .rd1_data_o (rd1_data),
        .rd2_data_o (rd2_data),
        .wr_i       (mem_fwd)
    );

    assign wb_valid_o = mem_fwd.wen;
    assign wb_addr_o  = mem_fwd.waddr;
    assign wb_data_o  = mem_fwd.wdata;

endmodule

//--- tests/mips_core_assertions.sv
`timescale 1ns/100ps

module mips_core_assertions (
    input logic                clk_i,
    input logic                rst_i,
    input logic                wb_valid_o,
    input mips_pkg::reg_addr_t wb_addr_o,
    input mips_pkg::word_t     wb_data_o
);

    // r0 writes are dropped in decode.
    a_no_r0_write: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_valid_o |-> wb_addr_o != '0)
        else $error("write strobe with destination r0");

    a_data_known: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_valid_o |-> !$isunknown(wb_data_o))
        else $error("write strobe with unknown data");

    // ========================================================================
    // reset behavior
    // ========================================================================

    a_quiet_in_reset: assert property (@(posedge clk_i)
        rst_i |=> !wb_valid_o)
        else $error("write strobe during reset");

    // pipeline still empty one cycle later.
    a_quiet_after_reset: assert property (@(posedge clk_i)
        $past(rst_i) |=> !wb_valid_o)
        else $error("write strobe in the first cycle after reset");

endmodule

bind mips_core mips_core_assertions u_assertions (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_valid_o (wb_valid_o),
    .wb_addr_o  (wb_addr_o),
    .wb_data_o  (wb_data_o)
);

//--- tests/tb_mips_core.sv
`timescale 1ns/100ps

module tb_mips_core;
    import mips_pkg::*;

    localparam int NUM_INSTS   = 2000;
    localparam int MAX_CYCLES  = 20000;
    localparam int DRAIN_LIMIT = 50;

    logic      clk_i = 1'b0;
    logic      rst_i;
    logic      inst_valid_i;
    word_t     inst_i;
    logic      wb_valid_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;

    integer    seed = 10;
    word_t     model [32];
    wb_t       exp_q [$];
    wb_t       exp_wr;
    wb_t       wr;
    word_t     inst;
    logic      valid;
    int        issued;
    int        cycles;
    int        wait_cycles;
    int        checked;
    int        valid_errors;
    int        addr_errors;
    int        data_errors;
    int        other_errors;

    mips_core dut_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    always #4 clk_i = ~clk_i;

    // ========================================================================
    // compare tasks
    // ========================================================================

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            valid_errors++;
            $display("[ERROR] %0t wb_valid_o: got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_addr(input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            addr_errors++;
            $display("[ERROR] %0t wb_addr_o: got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("[ERROR] %0t wb_data_o: got %h expected %h", $time, got, exp);
        end
    endtask

    // ========================================================================
    // random fields and reference model
    // ========================================================================

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // sources mostly r1..r4 to get close dependences.
    function automatic reg_addr_t pick_src();
        if (rand_below(4) != 0) begin
            return reg_addr_t'(1 + rand_below(4));
        end
        return reg_addr_t'(rand_below(32));
    endfunction

    function automatic reg_addr_t pick_dst();
        if (rand_below(16) == 0) begin
            return '0;
        end
        if (rand_below(4) != 0) begin
            return reg_addr_t'(1 + rand_below(4));
        end
        return reg_addr_t'(rand_below(32));
    endfunction

    function automatic logic is_kept_op(input logic [5:0] opc);
        return opc inside {OP_SPECIAL, OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_PREF,
                           OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU};
    endfunction

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sa,
                                     input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] opc, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // r0 as destination means no write.
    function automatic wb_t write_rec(input reg_addr_t dst, input word_t data);
        wb_t w;
        w.wen   = (dst != '0);
        w.waddr = dst;
        w.wdata = data;
        return w;
    endfunction

    task automatic make_inst(output word_t ins, output wb_t w);
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        logic [5:0]  opc;
        word_t       a;
        word_t       b;
        word_t       simm;
        word_t       zimm;
        rs   = pick_src();
        rt   = pick_src();
        rd   = pick_dst();
        sa   = 5'(rand_below(32));
        imm  = 16'(rand_below(65536));
        a    = model[rs];
        b    = model[rt];
        simm = {{16{imm[15]}}, imm};
        zimm = {16'h0000, imm};
        w    = '0;
        if (rand_below(8) == 0) begin
            opc = 6'(rand_below(64));
            if (is_kept_op(opc)) begin
                opc = 6'b111111;
            end
            ins = i_type(opc, rs, rd, imm);
        end else begin
            case (rand_below(27))
                0:  begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_OR);
                    w   = write_rec(rd, a | b);
                end
                1:  begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_AND);
                    w   = write_rec(rd, a & b);
                end
                2:  begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_XOR);
                    w   = write_rec(rd, a ^ b);
                end
                3:  begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_NOR);
                    w   = write_rec(rd, ~(a | b));
                end
                4:  begin
                    ins = r_type(5'd0, rt, rd, sa, FN_SLL);
                    w   = write_rec(rd, b << sa);
                end
                5:  begin
                    ins = r_type(5'd0, rt, rd, sa, FN_SRL);
                    w   = write_rec(rd, b >> sa);
                end
                6:  begin
                    ins = r_type(5'd0, rt, rd, sa, FN_SRA);
                    w   = write_rec(rd, $signed(b) >>> sa);
                end
                7:  begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_SLLV);
                    w   = write_rec(rd, b << a[4:0]);
                end
                8:  begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_SRLV);
                    w   = write_rec(rd, b >> a[4:0]);
                end
                9:  begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_SRAV);
                    w   = write_rec(rd, $signed(b) >>> a[4:0]);
                end
                10: begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_ADD);
                    w   = write_rec(rd, a + b);
                end
                11: begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_ADDU);
                    w   = write_rec(rd, a + b);
                end
                12: begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_SUB);
                    w   = write_rec(rd, a - b);
                end
                13: begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_SUBU);
                    w   = write_rec(rd, a - b);
                end
                14: begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_SLT);
                    w   = write_rec(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                end
                15: begin
                    ins = r_type(rs, rt, rd, 5'd0, FN_SLTU);
                    w   = write_rec(rd, (a < b) ? 32'd1 : 32'd0);
                end
                16: begin
                    ins = i_type(OP_ORI, rs, rd, imm);
                    w   = write_rec(rd, a | zimm);
                end
                17: begin
                    ins = i_type(OP_ANDI, rs, rd, imm);
                    w   = write_rec(rd, a & zimm);
                end
                18: begin
                    ins = i_type(OP_XORI, rs, rd, imm);
                    w   = write_rec(rd, a ^ zimm);
                end
                19: begin
                    ins = i_type(OP_LUI, rs, rd, imm);
                    w   = write_rec(rd, {imm, 16'h0000});
                end
                20: begin
                    ins = i_type(OP_ADDI, rs, rd, imm);
                    w   = write_rec(rd, a + simm);
                end
                21: begin
                    ins = i_type(OP_ADDIU, rs, rd, imm);
                    w   = write_rec(rd, a + simm);
                end
                22: begin
                    ins = i_type(OP_SLTI, rs, rd, imm);
                    w   = write_rec(rd, ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0);
                end
                // immediate is sign-extended, compare is unsigned.
                23: begin
                    ins = i_type(OP_SLTIU, rs, rd, imm);
                    w   = write_rec(rd, (a < simm) ? 32'd1 : 32'd0);
                end
                24: ins = r_type(5'd0, 5'd0, rd, sa, FN_SYNC);
                25: ins = i_type(OP_PREF, rs, rd, imm);
                default: ins = '0;
            endcase
        end
    endtask

    // ========================================================================
    // writeback monitor
    // ========================================================================

    always @(negedge clk_i) begin
        if (wb_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("unexpected write to r%0d at %0t", wb_addr_o, $time);
            end else begin
                exp_wr = exp_q.pop_front();
                check_addr(wb_addr_o, exp_wr.waddr);
                check_data(wb_data_o, exp_wr.wdata);
                checked++;
            end
        end
    end

    initial begin
        rst_i        = 1'b1;
        // a valid write held through reset must be dropped.
        inst_valid_i = 1'b1;
        inst_i       = i_type(OP_ORI, 5'd0, 5'd1, 16'hffff);
        checked      = 0;
        valid_errors = 0;
        addr_errors  = 0;
        data_errors  = 0;
        other_errors = 0;
        foreach (model[i]) begin
            model[i] = '0;
        end

        repeat (3) @(posedge clk_i);
        rst_i        <= 1'b0;
        inst_valid_i <= 1'b0;
        inst_i       <= '0;

        // idle after reset.
        repeat (6) begin
            @(negedge clk_i);
            check_valid(wb_valid_o, 1'b0);
        end

        issued = 0;
        cycles = 0;
        while (issued < NUM_INSTS && cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
            valid = (rand_below(10) < 8);
            make_inst(inst, wr);
            inst_valid_i <= valid;
            inst_i       <= inst;
            if (valid) begin
                issued++;
                if (wr.wen) begin
                    exp_q.push_back(wr);
                    model[wr.waddr] = wr.wdata;
                end
            end
        end
        if (issued < NUM_INSTS) begin
            other_errors++;
            $display("stimulus stopped after %0d of %0d instructions", issued, NUM_INSTS);
        end

        @(posedge clk_i);
        inst_valid_i <= 1'b0;
        inst_i       <= '0;

        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
            @(posedge clk_i);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("timed out with %0d writes never seen", exp_q.size());
        end

        // late extra writes still get flagged.
        repeat (8) @(posedge clk_i);

        $display("errors: valid %0d, addr %0d, data %0d, other %0d (%0d writes checked)",
                 valid_errors, addr_errors, data_errors, other_errors, checked);
        if (valid_errors + addr_errors + data_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
common/mips_pkg.sv
id/inst_decoder.sv
id/operand_fwd.sv
id/id_stage.sv
ex/ex_stage.sv
hdl/regfile.sv
hdl/mips_core.sv
tests/mips_core_assertions.sv
tests/tb_mips_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mips_core
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
